// ==== Makefile ====
# Verilator flow for the rename block
# every variable can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= rename_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_STR   ?= TESTBENCH PASSED
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
hw/rename_types_pkg.sv
hw/queue_cfg_pkg.sv
hw/isq_bus_if.sv
hw/slot_store.sv
hw/rename_line.sv
hw/rename_matrix.sv
hw/rename_top.sv
verification/rename_checker.sv
verification/rename_tb.sv

// ==== hw/isq_bus_if.sv ====
`timescale 1ns/100ps

// bundle between the slot store and the rename matrix
interface isq_bus_if;
  import queue_cfg_pkg::*;

  //////////////////////////////
  // store side
  //////////////////////////////

  // all eight slot lines, valid bits already folded in
  isq_line_t [ISQ_DEPTH-1:0] lines;
  // next slot a push lands in
  slot_t                     tail;

  //////////////////////////////
  // matrix side
  //////////////////////////////

  // one cycle pulse, the oldest half retires at the next edge
  logic                      seg_switch;
  // 0 when slots 0..3 are the oldest half, 1 when slots 4..7 are
  logic                      arch;

  // store owns the lines and tail, reacts to the switch
  modport store (
    output lines,
    output tail,
    input  seg_switch,
    input  arch
  );

  // matrix reads the lines and tail, owns switch and arch
  modport matrix (
    input  lines,
    input  tail,
    output seg_switch,
    output arch
  );

endinterface

// ==== hw/queue_cfg_pkg.sv ====
package queue_cfg_pkg;

  //////////////////////////////
  // queue geometry
  //////////////////////////////

  // eight slots, split into two halves of four
  localparam int ISQ_DEPTH  = 8;
  localparam int HALF_DEPTH = 4;
  localparam int SLOT_W     = 3;

  // slot index, also used for the tail pointer and read position
  typedef logic [SLOT_W-1:0] slot_t;

  // one issue queue slot as written by the host
  // wt is the wait bit, cleared once the instruction has issued
  typedef struct packed {
    logic                    vld;
    logic                    wt;
    logic                    src1_vld;
    rename_types_pkg::lreg_t src1;
    logic                    src2_vld;
    rename_types_pkg::lreg_t src2;
    logic                    dst_vld;
    rename_types_pkg::lreg_t dst;
    rename_types_pkg::preg_t pdest;
  } isq_line_t;

  // one renamed line as produced by the rename matrix
  typedef struct packed {
    logic                    vld;
    logic                    psrc1_vld;
    rename_types_pkg::preg_t psrc1;
    logic                    psrc2_vld;
    rename_types_pkg::preg_t psrc2;
    rename_types_pkg::preg_t pdest;
  } ren_line_t;

  // host operations on the slot store
  typedef enum logic {
    OP_PUSH       = 1'b0,
    OP_CLEAR_WAIT = 1'b1
  } host_op_e;

endpackage

// ==== hw/rename_line.sv ====
`timescale 1ns/100ps

module rename_line (
  input  rename_types_pkg::map_t   prv_map_i,
  input  queue_cfg_pkg::isq_line_t line_i,
  output rename_types_pkg::map_t   cur_map_o,
  output queue_cfg_pkg::ren_line_t ren_o,
  output rename_types_pkg::preg_t  free_preg_o
);
  import rename_types_pkg::*;
  import queue_cfg_pkg::*;

  // line actually writes its destination register
  logic  dst_wr;
  // source lookups
  logic  src1_on;
  logic  src2_on;
  // tag the destination held before this line
  preg_t old_tag;

  assign dst_wr  = line_i.vld & line_i.dst_vld;
  assign src1_on = line_i.vld & line_i.src1_vld;
  assign src2_on = line_i.vld & line_i.src2_vld;
  assign old_tag = prv_map_i[line_i.dst];

  //////////////////////////////
  // source rename
  //////////////////////////////

  // an invalid line reads back as all zero
  always_comb
  begin
    ren_o.vld       = line_i.vld;
    ren_o.psrc1_vld = src1_on;
    ren_o.psrc1     = src1_on ? prv_map_i[line_i.src1] : '0;
    ren_o.psrc2_vld = src2_on;
    ren_o.psrc2     = src2_on ? prv_map_i[line_i.src2] : '0;
    ren_o.pdest     = line_i.vld ? line_i.pdest : '0;
  end

  //////////////////////////////
  // map update
  //////////////////////////////

  // younger lines see pdest for this logical register
  always_comb
  begin
    cur_map_o = prv_map_i;
    if (dst_wr)
    begin
      cur_map_o[line_i.dst] = line_i.pdest;
    end
  end

  // displaced tag goes back to the free list once this line retires
  assign free_preg_o = dst_wr ? old_tag : '0;

endmodule

// ==== hw/rename_matrix.sv ====
`timescale 1ns/100ps

module rename_matrix (
  input  logic                     clk,
  input  logic                     rst_n,
  input  queue_cfg_pkg::slot_t     rd_pos_i,
  output queue_cfg_pkg::ren_line_t ren_o,
  output rename_types_pkg::preg_t  free_preg_o,
  output logic                     arch_o,
  isq_bus_if.matrix                bus
);
  import rename_types_pkg::*;
  import queue_cfg_pkg::*;

  // map entering and leaving each line
  map_t                 prv_map [ISQ_DEPTH];
  map_t                 cur_map [ISQ_DEPTH];
  // per line results in slot order
  ren_line_t            ren_line [ISQ_DEPTH];
  preg_t                free_preg [ISQ_DEPTH];
  // line is invalid or has issued
  logic [ISQ_DEPTH-1:0] done;

  // architectural mappings at the start of each half
  map_t                 top_hed_q;
  map_t                 mid_hed_q;
  logic                 arch_q;

  // switch decode
  logic                 lo_done;
  logic                 hi_done;
  logic                 tail_hi;
  logic                 seg_switch;
  slot_t                rd_slot;

  //////////////////////////////
  // rename line chain
  //////////////////////////////

  for (genvar g = 0; g < ISQ_DEPTH; g++)
  begin : g_line
    if (g == 0)
    begin : g_top
      // oldest half starts here when arch is 0, else wraps from line 7
      assign prv_map[g] = arch_q ? cur_map[ISQ_DEPTH-1] : top_hed_q;
    end
    else if (g == HALF_DEPTH)
    begin : g_mid
      // oldest half starts here when arch is 1
      assign prv_map[g] = arch_q ? mid_hed_q : cur_map[g-1];
    end
    else
    begin : g_chain
      assign prv_map[g] = cur_map[g-1];
    end

    rename_line u_rename_line (
      .prv_map_i   (prv_map[g]),
      .line_i      (bus.lines[g]),
      .cur_map_o   (cur_map[g]),
      .ren_o       (ren_line[g]),
      .free_preg_o (free_preg[g])
    );

    assign done[g] = ~bus.lines[g].vld | ~bus.lines[g].wt;
  end

  //////////////////////////////
  // segment switch
  //////////////////////////////

  assign lo_done = &done[HALF_DEPTH-1:0];
  assign hi_done = &done[ISQ_DEPTH-1:HALF_DEPTH];
  // msb of the tail tells which half new pushes go to
  assign tail_hi = bus.tail[SLOT_W-1];

  // oldest half fully issued and the tail has moved on past it
  assign seg_switch = (~arch_q & tail_hi & lo_done) |
                      (arch_q & ~tail_hi & hi_done);

  // header of the half becoming oldest captures the map handed to it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      top_hed_q <= RESET_MAP;
      mid_hed_q <= RESET_MAP;
      arch_q    <= 1'b0;
    end
    else if (seg_switch)
    begin
      if (arch_q)
      begin
        top_hed_q <= cur_map[ISQ_DEPTH-1];
      end
      else
      begin
        mid_hed_q <= cur_map[HALF_DEPTH-1];
      end
      arch_q <= ~arch_q;
    end
  end

  assign bus.seg_switch = seg_switch;
  assign bus.arch       = arch_q;
  assign arch_o         = arch_q;

  //////////////////////////////
  // reordered readout
  //////////////////////////////

  // oldest half always shows up at positions 0..3
  assign rd_slot = rd_pos_i + (arch_q ? slot_t'(HALF_DEPTH) : slot_t'(0));

  assign ren_o       = ren_line[rd_slot];
  assign free_preg_o = free_preg[rd_slot];

endmodule

// ==== hw/rename_top.sv ====
`timescale 1ns/100ps

module rename_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // host port, four-phase req/ack
  input  logic                     req_i,
  input  queue_cfg_pkg::host_op_e  op_i,
  input  queue_cfg_pkg::slot_t     slot_i,
  input  queue_cfg_pkg::isq_line_t line_i,
  output logic                     ack_o,
  // readout port
  input  queue_cfg_pkg::slot_t     rd_pos_i,
  output queue_cfg_pkg::ren_line_t ren_o,
  output rename_types_pkg::preg_t  free_preg_o,
  output logic                     arch_o,
  output logic                     full_o
);

  // store to matrix bundle
  isq_bus_if u_bus ();

  // host facing slot storage
  slot_store u_slot_store (
    .clk    (clk),
    .rst_n  (rst_n),
    .req_i  (req_i),
    .op_i   (op_i),
    .slot_i (slot_i),
    .line_i (line_i),
    .ack_o  (ack_o),
    .full_o (full_o),
    .bus    (u_bus.store)
  );

  // rename chain and segment headers
  rename_matrix u_rename_matrix (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_pos_i    (rd_pos_i),
    .ren_o       (ren_o),
    .free_preg_o (free_preg_o),
    .arch_o      (arch_o),
    .bus         (u_bus.matrix)
  );

endmodule

// ==== hw/rename_types_pkg.sv ====
package rename_types_pkg;

  //////////////////////////////
  // register geometry
  //////////////////////////////

  // logical register file seen by the instruction stream
  localparam int LREG_NUM = 4;
  localparam int LREG_W   = 2;

  // physical tag width, sixteen physical registers
  localparam int PREG_W   = 4;

  //////////////////////////////
  // tag and map types
  //////////////////////////////

  // index of a logical register
  typedef logic [LREG_W-1:0] lreg_t;

  // physical register tag
  typedef logic [PREG_W-1:0] preg_t;

  // full logical to physical map
  // entry k holds the physical tag of logical register k
  typedef preg_t [LREG_NUM-1:0] map_t;

  // identity map loaded into both segment headers at reset
  // logical k starts out on physical k
  localparam map_t RESET_MAP = {preg_t'(3), preg_t'(2), preg_t'(1), preg_t'(0)};

endpackage

// ==== hw/slot_store.sv ====
`timescale 1ns/100ps

module slot_store (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_i,
  input  queue_cfg_pkg::host_op_e  op_i,
  input  queue_cfg_pkg::slot_t     slot_i,
  input  queue_cfg_pkg::isq_line_t line_i,
  output logic                     ack_o,
  output logic                     full_o,
  isq_bus_if.store                 bus
);
  import queue_cfg_pkg::*;

  // four-phase acceptor state
  logic                   ack_q;
  logic                   accept;
  logic                   push_acc;
  logic                   clr_acc;

  // slot state
  logic [ISQ_DEPTH-1:0]   vld_q;
  logic [ISQ_DEPTH-1:0]   vld_nxt;
  logic [ISQ_DEPTH-1:0]   retire_mask;
  isq_line_t              slot_q [ISQ_DEPTH];
  slot_t                  tail_q;

  //////////////////////////////
  // host handshake
  //////////////////////////////

  // a request is taken once, on the first edge with req high and ack low
  assign accept   = req_i & ~ack_q;
  // pushes into a full queue still complete the handshake but store nothing
  assign push_acc = accept & (op_i == OP_PUSH) & ~full_o;
  assign clr_acc  = accept & (op_i == OP_CLEAR_WAIT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q <= 1'b0;
    end
    else if (accept)
    begin
      ack_q <= 1'b1;
    end
    // release only after the host has dropped req
    else if (!req_i)
    begin
      ack_q <= 1'b0;
    end
  end

  assign ack_o = ack_q;

  //////////////////////////////
  // tail pointer and full
  //////////////////////////////

  // tail wraps naturally at eight slots
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tail_q <= '0;
    end
    else if (push_acc)
    begin
      tail_q <= tail_q + slot_t'(1);
    end
  end

  // full one slot short of the oldest half
  // slot 7 with arch 0, slot 3 with arch 1
  assign full_o = bus.arch ? (tail_q == slot_t'(HALF_DEPTH - 1))
                           : (tail_q == slot_t'(ISQ_DEPTH - 1));

  //////////////////////////////
  // valid bits
  //////////////////////////////

  // half retiring on a segment switch
  assign retire_mask = {{HALF_DEPTH{bus.arch}}, {HALF_DEPTH{~bus.arch}}};

  always_comb
  begin
    vld_nxt = vld_q;
    // retired half drops out so the chain does not rename it again
    if (bus.seg_switch)
    begin
      vld_nxt = vld_nxt & ~retire_mask;
    end
    // the tail never sits in the retiring half, a push cannot collide
    if (push_acc)
    begin
      vld_nxt[tail_q] = line_i.vld;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vld_q <= '0;
    end
    else
    begin
      vld_q <= vld_nxt;
    end
  end

  //////////////////////////////
  // slot payload
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push_acc)
    begin
      slot_q[tail_q] <= line_i;
    end
    // issued instruction no longer blocks its half
    else if (clr_acc)
    begin
      slot_q[slot_i].wt <= 1'b0;
    end
  end

  // lines to the matrix carry the live valid bits
  always_comb
  begin
    for (int i = 0; i < ISQ_DEPTH; i++)
    begin
      bus.lines[i]     = slot_q[i];
      bus.lines[i].vld = vld_q[i];
    end
  end

  assign bus.tail = tail_q;

endmodule

// ==== verification/rename_checker.sv ====
`timescale 1ns/100ps

module rename_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_i,
  input  queue_cfg_pkg::host_op_e op_i,
  input  logic                    ack_i,
  input  logic                    full_i,
  input  logic                    arch_i
);
  import queue_cfg_pkg::*;

  // a push the store would take on this edge if not full
  logic push_req;

  assign push_req = req_i & ~ack_i & (op_i == OP_PUSH);

  //////////////////////////////
  // four-phase handshake
  //////////////////////////////

  // ack only answers a pending request
  ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack rose without a request");

  // host keeps req up until it has seen ack
  req_waits_ack : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req_i) |-> $past(ack_i))
    else $error("req dropped before ack");

  //////////////////////////////
  // full protection
  //////////////////////////////

  // an accepted push would move the tail off the full slot
  // full may only drop together with a segment switch
  full_blocks_push : assert property (@(posedge clk) disable iff (!rst_n)
    (push_req & full_i) |=> (full_i | (arch_i != $past(arch_i))))
    else $error("push taken while the queue was full");

endmodule

bind rename_top rename_checker u_rename_checker (
  .clk    (clk),
  .rst_n  (rst_n),
  .req_i  (req_i),
  .op_i   (op_i),
  .ack_i  (ack_o),
  .full_i (full_o),
  .arch_i (arch_o)
);

// ==== verification/rename_stimulus.txt ====
// kind 1 host op : 1 op slot vld wt s1v s1 s2v s2 dv d pdest  (op 0 push, 1 clear wait)
// kind 2 read    : 2 pos vld p1v p1 p2v p2 pdest free arch full 0
// after reset every position reads empty
2 0 0 0 0 0 0 0 0 0 0 0
2 1 0 0 0 0 0 0 0 0 0 0
2 2 0 0 0 0 0 0 0 0 0 0
2 3 0 0 0 0 0 0 0 0 0 0
2 4 0 0 0 0 0 0 0 0 0 0
2 5 0 0 0 0 0 0 0 0 0 0
2 6 0 0 0 0 0 0 0 0 0 0
2 7 0 0 0 0 0 0 0 0 0 0
// fill slots 0 to 4, all waiting
1 0 0 1 1 1 0 1 1 1 0 4
1 0 1 1 1 1 0 1 2 1 1 5
1 0 2 1 1 1 1 0 0 1 0 6
1 0 3 1 1 1 3 1 0 0 0 0
1 0 4 1 1 1 0 1 1 1 2 7
2 0 1 1 0 1 1 4 0 0 0 0
2 1 1 1 4 1 2 5 1 0 0 0
2 2 1 1 5 0 0 6 4 0 0 0
2 3 1 1 3 1 6 0 0 0 0 0
2 4 1 1 6 1 5 7 2 0 0 0
// issue slots 0 to 3, the lower half retires
1 1 0 0 0 0 0 0 0 0 0 0
1 1 1 0 0 0 0 0 0 0 0 0
1 1 2 0 0 0 0 0 0 0 0 0
1 1 3 0 0 0 0 0 0 0 0 0
2 0 1 1 6 1 5 7 2 1 0 0
2 4 0 0 0 0 0 0 0 1 0 0
2 5 0 0 0 0 0 0 0 1 0 0
2 6 0 0 0 0 0 0 0 1 0 0
2 7 0 0 0 0 0 0 0 1 0 0
// refill through the wrap up to full
1 0 5 1 1 1 2 1 3 1 3 8
1 0 6 1 1 1 3 0 0 1 0 9
1 0 7 1 1 1 0 1 1 1 1 a
1 0 0 1 1 1 1 1 0 1 2 b
1 0 1 1 1 1 2 1 3 1 3 c
1 0 2 1 1 1 3 0 0 1 0 d
2 1 1 1 7 1 3 8 3 1 1 0
2 2 1 1 8 0 0 9 6 1 1 0
2 3 1 1 9 1 5 a 5 1 1 0
2 4 1 1 a 1 9 b 7 1 1 0
2 5 1 1 b 1 8 c 8 1 1 0
2 6 1 1 c 0 0 d 9 1 1 0
// push into a full queue is dropped
1 0 3 1 1 1 0 0 0 1 1 e
2 0 1 1 6 1 5 7 2 1 1 0
2 6 1 1 c 0 0 d 9 1 1 0
2 7 0 0 0 0 0 0 0 1 1 0

// ==== verification/rename_tb.sv ====
`timescale 1ns/100ps

module rename_tb;
  import rename_types_pkg::*;
  import queue_cfg_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;
  // words per stimulus record and room for records
  localparam int REC_W      = 12;
  localparam int MAX_REC    = 64;
  // worst case cycles for one record, handshake plus settle time
  localparam int REC_CYCLES = 16;

  localparam logic [7:0] KIND_TXN  = 8'h1;
  localparam logic [7:0] KIND_READ = 8'h2;

  logic      clk;
  logic      rst_n;
  logic      req_i;
  host_op_e  op_i;
  slot_t     slot_i;
  isq_line_t line_i;
  logic      ack_o;
  slot_t     rd_pos_i;
  ren_line_t ren_o;
  preg_t     free_preg_o;
  logic      arch_o;
  logic      full_o;

  // raw stimulus words, REC_W per record
  logic [7:0] stim [MAX_REC*REC_W];
  int         n_rec;
  logic       loaded;

  rename_top u_rename_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .op_i        (op_i),
    .slot_i      (slot_i),
    .line_i      (line_i),
    .ack_o       (ack_o),
    .rd_pos_i    (rd_pos_i),
    .ren_o       (ren_o),
    .free_preg_o (free_preg_o),
    .arch_o      (arch_o),
    .full_o      (full_o)
  );

  //////////////////////////////
  // clock and watchdog
  //////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // limit scales with the number of records in the file
  initial
  begin
    wait (loaded);
    #(CLK_PERIOD * (RST_CYCLES + n_rec * REC_CYCLES));
    $display("watchdog expired before all records were processed");
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic report_mismatch(input string what, input int pos,
                                 input logic [31:0] got, input logic [31:0] expected);
    $display("[ERROR] time %0t: %s at read position %0d is %h, expected %h",
             $time, what, pos, got, expected);
    $display("TESTBENCH FAILED");
    $fatal(1, "readout mismatch");
  endtask

  // ack is sampled mid cycle, away from the driving edge
  task automatic wait_ack(input logic level);
    @(negedge clk);
    while (ack_o !== level)
    begin
      @(negedge clk);
    end
  endtask

  // one full four-phase transfer
  task automatic host_transaction(input int base);
    isq_line_t ln;
    ln.vld      = stim[base+3][0];
    ln.wt       = stim[base+4][0];
    ln.src1_vld = stim[base+5][0];
    ln.src1     = lreg_t'(stim[base+6]);
    ln.src2_vld = stim[base+7][0];
    ln.src2     = lreg_t'(stim[base+8]);
    ln.dst_vld  = stim[base+9][0];
    ln.dst      = lreg_t'(stim[base+10]);
    ln.pdest    = preg_t'(stim[base+11]);
    @(posedge clk);
    op_i   <= host_op_e'(stim[base+1][0]);
    slot_i <= slot_t'(stim[base+2]);
    line_i <= ln;
    req_i  <= 1'b1;
    wait_ack(1'b1);
    @(posedge clk);
    req_i <= 1'b0;
    wait_ack(1'b0);
    // a segment switch lands before the next read
    repeat (2) @(posedge clk);
  endtask

  // select a position and compare the combinational readout
  task automatic check_readout(input int base);
    ren_line_t exp_ren;
    preg_t     exp_free;
    logic      exp_arch;
    logic      exp_full;
    int        pos;
    pos               = int'(stim[base+1]);
    exp_ren.vld       = stim[base+2][0];
    exp_ren.psrc1_vld = stim[base+3][0];
    exp_ren.psrc1     = preg_t'(stim[base+4]);
    exp_ren.psrc2_vld = stim[base+5][0];
    exp_ren.psrc2     = preg_t'(stim[base+6]);
    exp_ren.pdest     = preg_t'(stim[base+7]);
    exp_free          = preg_t'(stim[base+8]);
    exp_arch          = stim[base+9][0];
    exp_full          = stim[base+10][0];
    @(posedge clk);
    rd_pos_i <= slot_t'(pos);
    @(negedge clk);
    assert (ren_o === exp_ren)
    else
    begin
      report_mismatch("renamed line", pos, 32'(ren_o), 32'(exp_ren));
    end
    assert (free_preg_o === exp_free)
    else
    begin
      report_mismatch("free tag", pos, 32'(free_preg_o), 32'(exp_free));
    end
    assert (arch_o === exp_arch)
    else
    begin
      report_mismatch("arch bit", pos, 32'(arch_o), 32'(exp_arch));
    end
    assert (full_o === exp_full)
    else
    begin
      report_mismatch("full flag", pos, 32'(full_o), 32'(exp_full));
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    int base;
    req_i    = 1'b0;
    op_i     = OP_PUSH;
    slot_i   = '0;
    line_i   = '0;
    rd_pos_i = '0;
    rst_n    = 1'b0;
    loaded   = 1'b0;
    n_rec    = 0;
    $readmemh("verification/rename_stimulus.txt", stim);
    // records run until the first word that is no known kind
    while (n_rec < MAX_REC &&
           (stim[n_rec*REC_W] === KIND_TXN || stim[n_rec*REC_W] === KIND_READ))
    begin
      n_rec++;
    end
    assert (n_rec > 0)
    else
    begin
      $display("no records found in verification/rename_stimulus.txt");
      $display("TESTBENCH FAILED");
      $fatal(1, "empty stimulus");
    end
    loaded = 1'b1;

    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int r = 0; r < n_rec; r++)
    begin
      base = r * REC_W;
      if (stim[base] === KIND_TXN)
      begin
        host_transaction(base);
      end
      else
      begin
        check_readout(base);
      end
    end

    repeat (2) @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
